// ==== dbg_bus_pkg.sv ====
//////////////////////////////////////////////////
// Debug bus definitions
// Widths and packed structs of the AXI-lite debug
// slave port and of its skid buffer payloads
//////////////////////////////////////////////////
package dbg_bus_pkg;

	// Debug word width and byte offset bits below a word
	localparam int DBG_DATA_WIDTH = 32;
	localparam int DBG_LSB = $clog2(DBG_DATA_WIDTH/8);
	// Full byte address as carried on the bus
	localparam int DBG_AXIL_ADDR_WIDTH = 32;
	// Word address seen past the skid buffers
	localparam int DBG_WADDR_WIDTH = 6;

	typedef logic [DBG_WADDR_WIDTH-1:0] dbg_waddr_t;

	// Write data and byte strobes travel together
	typedef struct packed {
		logic [DBG_DATA_WIDTH-1:0]   data;
		logic [DBG_DATA_WIDTH/8-1:0] strb;
	} dbg_wr_payload_t;

	// Everything the host drives
	typedef struct packed {
		logic                           awvalid;
		logic [DBG_AXIL_ADDR_WIDTH-1:0] awaddr;
		logic                           wvalid;
		logic [DBG_DATA_WIDTH-1:0]      wdata;
		logic [DBG_DATA_WIDTH/8-1:0]    wstrb;
		logic                           bready;
		logic                           arvalid;
		logic [DBG_AXIL_ADDR_WIDTH-1:0] araddr;
		logic                           rready;
	} dbg_axil_req_t;

	// Everything the slave drives back
	typedef struct packed {
		logic                      awready;
		logic                      wready;
		logic                      bvalid;
		logic [1:0]                bresp;
		logic                      arready;
		logic                      rvalid;
		logic [DBG_DATA_WIDTH-1:0] rdata;
		logic [1:0]                rresp;
	} dbg_axil_rsp_t;

endpackage

// ==== cpu_ctrl_pkg.sv ====
//////////////////////////////////////////////////
// CPU control definitions
// Control word bits, status word layout and the
// structs of the CPU debug port
//////////////////////////////////////////////////
package cpu_ctrl_pkg;

	// Word address bit that picks the control register
	localparam int CTRL_SEL_BIT = 5;

	// Control word bits
	localparam int RESET_BIT       = 6;
	localparam int STEP_BIT        = 8;
	localparam int HALT_BIT        = 10;
	localparam int CLEAR_CACHE_BIT = 11;

	// Status word, listed from bit 31 down to bit 0
	typedef struct packed {
		logic [14:0] rsvd_hi;
		logic        interrupt_hi;
		logic        brk;
		logic [2:0]  cc;
		logic        rsvd_11;
		logic        halt_cmd;
		logic        halted;
		logic        rsvd_8;
		logic        interrupt;
		logic        cpu_reset;
		logic [5:0]  rsvd_lo;
	} cpu_status_t;

	// Toward the core
	typedef struct packed {
		logic        cpu_reset;
		logic        halt;
		logic        clear_cache;
		logic        we;
		logic [4:0]  wreg;
		logic [31:0] wdata;
		logic [4:0]  rreg;
	} cpu_dbg_cmd_t;

	// From the core
	typedef struct packed {
		logic        stall;
		logic        brk;
		logic [2:0]  cc;
		logic [31:0] rdata;
	} cpu_dbg_rsp_t;

	// One accepted control write
	typedef struct packed {
		logic        valid;
		logic [3:0]  strb;
		logic [31:0] data;
	} dbg_cmd_t;

endpackage

// ==== skid_buffer.sv ====
//////////////////////////////////////////////////
// Skid buffer
// Valid/ready stage with one spare entry, payload
// type chosen per instance
//////////////////////////////////////////////////
`timescale 1ns/1ps

module skid_buffer #(
	parameter type T = logic [7:0]
) (
	input  logic S_AXI_ACLK,
	input  logic S_AXI_ARESETN,
	// Upstream side
	input  logic i_valid,
	output logic o_ready,
	input  T     i_data,
	// Downstream side
	output logic o_valid,
	input  logic i_ready,
	output T     o_data
);

	// Spare entry
	logic r_valid;
	T     r_data;

	// Spare fills when a beat arrives that downstream refuses
	always_ff @(posedge S_AXI_ACLK)
	if (!S_AXI_ARESETN)
		r_valid <= 1'b0;
	else if (i_valid && o_ready && o_valid && !i_ready)
		r_valid <= 1'b1;
	else if (i_ready)
		r_valid <= 1'b0;

	// Capture whenever the spare is free
	always_ff @(posedge S_AXI_ACLK)
	if (o_ready)
		r_data <= i_data;

	// Bus ready only hangs on the spare
	assign o_ready = !r_valid;

	// Spare entry first, else pass straight through
	assign o_valid = i_valid || r_valid;
	assign o_data  = r_valid ? r_data : i_data;

endmodule

// ==== reset_hold_timer.sv ====
//////////////////////////////////////////////////
// Reset hold timer
// Keeps the CPU in reset for a fixed count
//////////////////////////////////////////////////
`timescale 1ns/1ps

module reset_hold_timer #(
	parameter int RESET_DURATION = 10
) (
	input  logic S_AXI_ACLK,
	input  logic S_AXI_ARESETN,
	input  logic i_cpu_reset,
	output logic o_hold
);

	localparam int CW = (RESET_DURATION > 1) ? $clog2(RESET_DURATION+1) : 1;

	logic [CW-1:0] count;

	// Down-counter, reloaded on either reset
	always_ff @(posedge S_AXI_ACLK)
	if (!S_AXI_ARESETN || i_cpu_reset)
		count <= CW'(RESET_DURATION);
	else if (count != '0)
		count <= count - 1'b1;

	// Hold drops as the count reaches its last step
	always_ff @(posedge S_AXI_ACLK)
	if (!S_AXI_ARESETN || i_cpu_reset)
		o_hold <= (RESET_DURATION > 0);
	else
		o_hold <= (count > 1);

endmodule

// ==== cpu_cmd_fsm.sv ====
//////////////////////////////////////////////////
// CPU run control
// Reset, halt, single step and cache clear state
// machine driven by debug control writes
//////////////////////////////////////////////////
`timescale 1ns/1ps

module cpu_cmd_fsm #(
	parameter bit START_HALTED = 1'b0
) (
	input  logic                   S_AXI_ACLK,
	input  logic                   S_AXI_ARESETN,
	input  logic                   i_cpu_reset,
	input  logic                   i_hold,
	input  cpu_ctrl_pkg::dbg_cmd_t i_cmd,
	input  logic                   i_reg_write_accept,
	input  logic                   i_reg_write_pending,
	input  logic                   i_stall,
	input  logic                   i_brk,
	output logic                   o_cpu_reset,
	output logic                   o_halt,
	output logic                   o_clear_cache
);

	import cpu_ctrl_pkg::*;

	typedef enum logic [2:0] {
		ST_RESETTING,
		ST_RUNNING,
		ST_HALTED,
		ST_STEPPING,
		ST_CLEARING
	} state_t;

	state_t state, state_nxt;

	// Byte lanes of the control write
	logic cmd_b0, cmd_b1;
	logic halt_req, step_req, release_req, clear_req, reset_req;

	assign cmd_b0 = i_cmd.valid && i_cmd.strb[0];
	assign cmd_b1 = i_cmd.valid && i_cmd.strb[1];

	// Halt only when step is not asked for too
	assign halt_req = cmd_b1 && i_cmd.data[HALT_BIT] && !i_cmd.data[STEP_BIT];
	assign step_req = cmd_b1 && i_cmd.data[STEP_BIT];
	// Never let go while a register write is still outstanding
	assign release_req = cmd_b1 && (!i_cmd.data[HALT_BIT] || i_cmd.data[STEP_BIT])
		&& !i_reg_write_pending && !i_stall;
	assign clear_req = cmd_b1 && i_cmd.data[CLEAR_CACHE_BIT];
	// Break resets the core unless it starts halted
	assign reset_req = i_hold || (i_brk && !START_HALTED)
		|| (cmd_b0 && i_cmd.data[RESET_BIT]);

	//////////////////////////////////////////////////
	// Next state
	//////////////////////////////////////////////////
	always_comb
	begin
		state_nxt = state;
		case (state)
		ST_RESETTING:
			state_nxt = START_HALTED ? ST_HALTED : ST_RUNNING;
		ST_RUNNING:
			if (step_req)
				state_nxt = ST_STEPPING;
		ST_HALTED:
			if (release_req)
				state_nxt = i_cmd.data[STEP_BIT] ? ST_STEPPING : ST_RUNNING;
		// Both end once the core goes quiet
		ST_STEPPING, ST_CLEARING:
			if (!i_stall)
				state_nxt = ST_HALTED;
		default:
			state_nxt = ST_RESETTING;
		endcase

		// Halt requests, an ongoing clear keeps running
		if (state != ST_CLEARING
				&& (halt_req || i_reg_write_accept || (i_brk && START_HALTED)))
			state_nxt = ST_HALTED;

		// Cache clear needs the halt bit alongside it
		if (clear_req)
		begin
			if (i_cmd.data[HALT_BIT] || state == ST_CLEARING)
				state_nxt = ST_CLEARING;
			else
				state_nxt = ST_HALTED;
		end

		// Reset wins over everything
		if (reset_req)
			state_nxt = ST_RESETTING;
	end

	always_ff @(posedge S_AXI_ACLK)
	if (!S_AXI_ARESETN || i_cpu_reset)
		state <= ST_RESETTING;
	else
		state <= state_nxt;

	//////////////////////////////////////////////////
	// Outputs decoded from state
	//////////////////////////////////////////////////
	assign o_cpu_reset = (state == ST_RESETTING);
	assign o_halt = (state == ST_RESETTING) ? START_HALTED
		: (state == ST_HALTED || state == ST_CLEARING);
	assign o_clear_cache = (state == ST_CLEARING);

endmodule

// ==== dbg_write_path.sv ====
//////////////////////////////////////////////////
// Debug write path
// Accepts debug writes, splits control from register
// writes and returns the write response
//////////////////////////////////////////////////
`timescale 1ns/1ps

module dbg_write_path #(
	parameter int DBG_ADDR_WIDTH = 8
) (
	input  logic                                     S_AXI_ACLK,
	input  logic                                     S_AXI_ARESETN,
	// Write address
	input  logic                                     i_aw_valid,
	input  logic [DBG_ADDR_WIDTH-dbg_bus_pkg::DBG_LSB-1:0] i_aw_addr,
	output logic                                     o_aw_ready,
	// Write data
	input  logic                                     i_w_valid,
	input  dbg_bus_pkg::dbg_wr_payload_t             i_w_data,
	output logic                                     o_w_ready,
	// Write response
	input  logic                                     i_bready,
	output logic                                     o_bvalid,
	// Core side
	input  logic                                     i_stall,
	output cpu_ctrl_pkg::dbg_cmd_t                   o_cmd,
	output logic                                     o_reg_write_accept,
	output logic                                     o_reg_write_pending,
	output logic                                     o_we,
	output logic [4:0]                               o_wreg,
	output logic [dbg_bus_pkg::DBG_DATA_WIDTH-1:0]   o_wdata
);

	import cpu_ctrl_pkg::*;

	logic is_ctrl, has_strb, write_ready;

	assign is_ctrl  = i_aw_addr[CTRL_SEL_BIT];
	assign has_strb = |i_w_data.strb;

	// Address and data together, B free, and no register
	// write stuck behind a stalled core
	assign write_ready = i_aw_valid && i_w_valid
		&& (!has_strb || is_ctrl || !i_stall || !o_we)
		&& (!o_bvalid || i_bready);

	assign o_aw_ready = write_ready;
	assign o_w_ready  = write_ready;

	//////////////////////////////////////////////////
	// Register write toward the core
	//////////////////////////////////////////////////
	// we holds until the core takes it
	always_ff @(posedge S_AXI_ACLK)
	if (!S_AXI_ARESETN)
		o_we <= 1'b0;
	else if (!o_we || !i_stall)
		o_we <= write_ready && has_strb && !is_ctrl;

	always_ff @(posedge S_AXI_ACLK)
	if (!o_we || !i_stall)
	begin
		o_wreg  <= i_aw_addr[4:0];
		o_wdata <= i_w_data.data;
	end

	assign o_reg_write_accept  = write_ready && has_strb && !is_ctrl;
	assign o_reg_write_pending = o_we;

	// Control write strobe for the run control
	assign o_cmd.valid = write_ready && is_ctrl;
	assign o_cmd.strb  = i_w_data.strb;
	assign o_cmd.data  = i_w_data.data;

	//////////////////////////////////////////////////
	// Write response
	//////////////////////////////////////////////////
	always_ff @(posedge S_AXI_ACLK)
	if (!S_AXI_ARESETN)
		o_bvalid <= 1'b0;
	else if (write_ready)
		o_bvalid <= 1'b1;
	else if (i_bready)
		o_bvalid <= 1'b0;

endmodule

// ==== dbg_read_path.sv ====
//////////////////////////////////////////////////
// Debug read path
// One read at a time, status word or core register
//////////////////////////////////////////////////
`timescale 1ns/1ps

module dbg_read_path #(
	parameter int DBG_ADDR_WIDTH = 8
) (
	input  logic                                     S_AXI_ACLK,
	input  logic                                     S_AXI_ARESETN,
	// Read address
	input  logic                                     i_ar_valid,
	input  logic [DBG_ADDR_WIDTH-dbg_bus_pkg::DBG_LSB-1:0] i_ar_addr,
	output logic                                     o_ar_ready,
	// Read data
	input  logic                                     i_rready,
	output logic                                     o_rvalid,
	output logic [dbg_bus_pkg::DBG_DATA_WIDTH-1:0]   o_rdata,
	// Core side
	output logic [4:0]                               o_rreg,
	input  logic [dbg_bus_pkg::DBG_DATA_WIDTH-1:0]   i_core_rdata,
	input  cpu_ctrl_pkg::cpu_status_t                i_status
);

	import cpu_ctrl_pkg::*;

	logic read_ready, is_ctrl;
	// Register read waiting on core data
	logic reg_pending;

	assign is_ctrl = i_ar_addr[CTRL_SEL_BIT];

	assign read_ready = i_ar_valid && !reg_pending && (!o_rvalid || i_rready);
	assign o_ar_ready = read_ready;

	// Core answers this one cycle later
	assign o_rreg = i_ar_addr[4:0];

	always_ff @(posedge S_AXI_ACLK)
	if (!S_AXI_ARESETN)
		reg_pending <= 1'b0;
	else
		reg_pending <= read_ready && !is_ctrl;

	// Status answers at once, registers a cycle later
	always_ff @(posedge S_AXI_ACLK)
	if (!S_AXI_ARESETN)
		o_rvalid <= 1'b0;
	else if (!o_rvalid || i_rready)
		o_rvalid <= (read_ready && is_ctrl) || reg_pending;

	always_ff @(posedge S_AXI_ACLK)
	if (!o_rvalid || i_rready)
		o_rdata <= reg_pending ? i_core_rdata : i_status;

endmodule

// ==== zip_dbg_ctrl.sv ====
//////////////////////////////////////////////////
// Debug control port
// AXI-lite debug slave for the CPU wrapper, with
// run control, reset hold and status readback
//////////////////////////////////////////////////
`timescale 1ns/1ps

module zip_dbg_ctrl #(
	parameter int DBG_ADDR_WIDTH = 8,
	parameter int RESET_DURATION = 10,
	parameter bit START_HALTED   = 1'b0
) (
	input  logic                           S_AXI_ACLK,
	input  logic                           S_AXI_ARESETN,
	input  logic                           i_interrupt,
	input  logic                           i_cpu_reset,
	// Debug bus
	input  dbg_bus_pkg::dbg_axil_req_t     i_dbg_axil,
	output wire dbg_bus_pkg::dbg_axil_rsp_t o_dbg_axil,
	// CPU debug port
	input  cpu_ctrl_pkg::cpu_dbg_rsp_t     i_cpu_dbg,
	output wire cpu_ctrl_pkg::cpu_dbg_cmd_t o_cpu_dbg
);

	import dbg_bus_pkg::*;
	import cpu_ctrl_pkg::*;

	// Skid buffer outputs
	logic            aw_valid, w_valid, ar_valid;
	logic            aw_ready, w_ready, ar_ready;
	dbg_waddr_t      aw_addr, ar_addr;
	dbg_wr_payload_t w_in, w_data;

	// Between the paths and run control
	dbg_cmd_t    cmd;
	logic        reg_write_accept, reg_write_pending;
	logic        hold;
	cpu_status_t status;

	//////////////////////////////////////////////////
	// Skid buffers
	//////////////////////////////////////////////////
	assign w_in = '{data: i_dbg_axil.wdata, strb: i_dbg_axil.wstrb};

	skid_buffer #(.T(dbg_waddr_t)) aw_skid (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid(i_dbg_axil.awvalid),
		.o_ready(o_dbg_axil.awready),
		.i_data(i_dbg_axil.awaddr[DBG_ADDR_WIDTH-1:DBG_LSB]),
		.o_valid(aw_valid),
		.i_ready(aw_ready),
		.o_data(aw_addr)
	);

	skid_buffer #(.T(dbg_wr_payload_t)) w_skid (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid(i_dbg_axil.wvalid),
		.o_ready(o_dbg_axil.wready),
		.i_data(w_in),
		.o_valid(w_valid),
		.i_ready(w_ready),
		.o_data(w_data)
	);

	skid_buffer #(.T(dbg_waddr_t)) ar_skid (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid(i_dbg_axil.arvalid),
		.o_ready(o_dbg_axil.arready),
		.i_data(i_dbg_axil.araddr[DBG_ADDR_WIDTH-1:DBG_LSB]),
		.o_valid(ar_valid),
		.i_ready(ar_ready),
		.o_data(ar_addr)
	);

	//////////////////////////////////////////////////
	// Write and read paths
	//////////////////////////////////////////////////
	dbg_write_path #(.DBG_ADDR_WIDTH(DBG_ADDR_WIDTH)) write_path (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_aw_valid(aw_valid),
		.i_aw_addr(aw_addr),
		.o_aw_ready(aw_ready),
		.i_w_valid(w_valid),
		.i_w_data(w_data),
		.o_w_ready(w_ready),
		.i_bready(i_dbg_axil.bready),
		.o_bvalid(o_dbg_axil.bvalid),
		.i_stall(i_cpu_dbg.stall),
		.o_cmd(cmd),
		.o_reg_write_accept(reg_write_accept),
		.o_reg_write_pending(reg_write_pending),
		.o_we(o_cpu_dbg.we),
		.o_wreg(o_cpu_dbg.wreg),
		.o_wdata(o_cpu_dbg.wdata)
	);

	dbg_read_path #(.DBG_ADDR_WIDTH(DBG_ADDR_WIDTH)) read_path (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_ar_valid(ar_valid),
		.i_ar_addr(ar_addr),
		.o_ar_ready(ar_ready),
		.i_rready(i_dbg_axil.rready),
		.o_rvalid(o_dbg_axil.rvalid),
		.o_rdata(o_dbg_axil.rdata),
		.o_rreg(o_cpu_dbg.rreg),
		.i_core_rdata(i_cpu_dbg.rdata),
		.i_status(status)
	);

	// Responses are always OKAY
	assign o_dbg_axil.bresp = 2'b00;
	assign o_dbg_axil.rresp = 2'b00;

	//////////////////////////////////////////////////
	// Run control
	//////////////////////////////////////////////////
	reset_hold_timer #(.RESET_DURATION(RESET_DURATION)) hold_timer (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_cpu_reset(i_cpu_reset),
		.o_hold(hold)
	);

	cpu_cmd_fsm #(.START_HALTED(START_HALTED)) cmd_fsm (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_cpu_reset(i_cpu_reset),
		.i_hold(hold),
		.i_cmd(cmd),
		.i_reg_write_accept(reg_write_accept),
		.i_reg_write_pending(reg_write_pending),
		.i_stall(i_cpu_dbg.stall),
		.i_brk(i_cpu_dbg.brk),
		.o_cpu_reset(o_cpu_dbg.cpu_reset),
		.o_halt(o_cpu_dbg.halt),
		.o_clear_cache(o_cpu_dbg.clear_cache)
	);

	// Status word, halted means the core is not stalled
	assign status = '{
		rsvd_hi:      '0,
		interrupt_hi: i_interrupt,
		brk:          i_cpu_dbg.brk,
		cc:           i_cpu_dbg.cc,
		rsvd_11:      1'b0,
		halt_cmd:     o_cpu_dbg.halt,
		halted:       !i_cpu_dbg.stall,
		rsvd_8:       1'b0,
		interrupt:    i_interrupt,
		cpu_reset:    o_cpu_dbg.cpu_reset,
		rsvd_lo:      '0
	};

endmodule

// ==== tb_zip_dbg_ctrl.sv ====
//////////////////////////////////////////////////
// Debug control port testbench
// Core model, status reference, run control tests
// and random traffic under back-pressure
//////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_zip_dbg_ctrl;

	import dbg_bus_pkg::*;
	import cpu_ctrl_pkg::*;

	localparam int DBG_ADDR_WIDTH = 8;
	localparam int RESET_DURATION = 10;
	localparam bit START_HALTED = 1'b0;
	// Byte address 0x80 sets word address bit 5
	localparam logic [31:0] CTRL_ADDR = 32'h0000_0080;
	// Watchdog allows 40 cycles per transaction
	localparam int N_RAND = 48;
	localparam int N_TXN = N_RAND + 32 + 20;
	localparam int WATCHDOG_CYCLES = N_TXN * 40 + RESET_DURATION + 20;

	logic S_AXI_ACLK;
	logic S_AXI_ARESETN;
	// Host side of the debug bus
	logic        awvalid, wvalid, bready, arvalid, rready;
	logic [31:0] awaddr, wdata, araddr;
	logic [3:0]  wstrb;
	// Core side
	logic        stall, brk, interrupt, cpu_reset_in;
	logic [2:0]  cc;
	logic [31:0] core_rdata;
	logic [31:0] core_regs [32];
	int          core_wr_count;
	logic [4:0]  core_last_wreg;
	logic [31:0] core_last_wdata;

	dbg_axil_req_t dbg_req;
	dbg_axil_rsp_t dbg_rsp;
	cpu_dbg_rsp_t  cpu_rsp;
	cpu_dbg_cmd_t  cpu_cmd;

	// Testbench state
	logic [15:0] lfsr;
	logic        bp_en;
	logic        exp_halt, exp_reset;
	logic [31:0] mirror [32];
	logic [31:0] exp_q [$];
	logic [31:0] exp_rdata;
	int          b_count;

	assign dbg_req = '{awvalid: awvalid, awaddr: awaddr, wvalid: wvalid, wdata: wdata,
		wstrb: wstrb, bready: bready, arvalid: arvalid, araddr: araddr, rready: rready};
	assign cpu_rsp = '{stall: stall, brk: brk, cc: cc, rdata: core_rdata};

	zip_dbg_ctrl #(
		.DBG_ADDR_WIDTH(DBG_ADDR_WIDTH),
		.RESET_DURATION(RESET_DURATION),
		.START_HALTED(START_HALTED)
	) i_zip_dbg_ctrl (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_interrupt(interrupt),
		.i_cpu_reset(cpu_reset_in),
		.i_dbg_axil(dbg_req),
		.o_dbg_axil(dbg_rsp),
		.i_cpu_dbg(cpu_rsp),
		.o_cpu_dbg(cpu_cmd)
	);

	initial S_AXI_ACLK = 1'b0;
	always #2 S_AXI_ACLK = !S_AXI_ACLK;

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////
	// 16-bit Galois LFSR with taps 16,14,13,11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// Power-up register contents spread over all index bits
	function automatic logic [31:0] fill_word(input int idx);
		logic [31:0] a;
		a = 32'(idx);
		return 32'h5A00_0000 ^ (a * 32'h0101_0101) ^ {a[4:0], 27'd0};
	endfunction

	// Status word as laid out bit by bit
	function automatic logic [31:0] exp_status(input logic rst, input logic irq,
		input logic halt_cmd, input logic stl, input logic brk_in, input logic [2:0] cc_in);
		logic [31:0] s;
		s = '0;
		s[6] = rst;
		s[7] = irq;
		s[9] = !stl;
		s[10] = halt_cmd;
		s[14:12] = cc_in;
		s[15] = brk_in;
		s[16] = irq;
		return s;
	endfunction

	task automatic rand_bit(output logic b);
		b = lfsr[0];
		lfsr = lfsr_next(lfsr);
	endtask

	task automatic rand_bits(input int n, output logic [31:0] v);
		logic b;
		v = '0;
		for (int k = 0; k < n; k++)
		begin
			rand_bit(b);
			v = {v[30:0], b};
		end
	endtask

	task automatic stop_on_error();
		$display("=== FAIL ===");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic check_word(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			$display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		assert (got === exp)
		else
		begin
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
			stop_on_error();
		end
	endtask

	// Advance one cycle and drive inputs 1 ns after the edge
	task automatic tick();
		@(posedge S_AXI_ACLK);
		#1;
		if (bp_en)
		begin
			rand_bit(stall);
			rand_bit(bready);
			rand_bit(rready);
		end
	endtask

	// AW and W until both have been taken
	task automatic send_write(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		logic aw_done, w_done;
		aw_done = 1'b0;
		w_done = 1'b0;
		awvalid = 1'b1;
		awaddr = addr;
		wvalid = 1'b1;
		wdata = data;
		wstrb = strb;
		while (!aw_done || !w_done)
		begin
			@(negedge S_AXI_ACLK);
			if (awvalid && dbg_rsp.awready)
				aw_done = 1'b1;
			if (wvalid && dbg_rsp.wready)
				w_done = 1'b1;
			tick();
			awvalid = !aw_done;
			wvalid = !w_done;
		end
	endtask

	task automatic wait_bresp(input int start);
		while (b_count == start)
			tick();
	endtask

	task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		int start;
		start = b_count;
		send_write(addr, data, strb);
		wait_bresp(start);
	endtask

	// Queue the expected word, then wait for the compare to drain it
	task automatic read_word(input logic [31:0] addr, input logic [31:0] expected);
		logic done;
		exp_q.push_back(expected);
		arvalid = 1'b1;
		araddr = addr;
		done = 1'b0;
		while (!done)
		begin
			@(negedge S_AXI_ACLK);
			done = dbg_rsp.arready;
			tick();
		end
		arvalid = 1'b0;
		while (exp_q.size() != 0)
			tick();
	endtask

	task automatic wait_we_idle();
		while (cpu_cmd.we)
			tick();
	endtask

	//////////////////////////////////////////////////
	// Core model
	//////////////////////////////////////////////////
	always @(posedge S_AXI_ACLK)
	if (!S_AXI_ARESETN)
	begin
		for (int i = 0; i < 32; i++)
			core_regs[i] <= fill_word(i);
		core_rdata <= '0;
		core_wr_count <= 0;
	end
	else
	begin
		// Read data one cycle behind rreg
		core_rdata <= core_regs[cpu_cmd.rreg];
		if (cpu_cmd.we && !stall)
		begin
			core_regs[cpu_cmd.wreg] <= cpu_cmd.wdata;
			core_wr_count <= core_wr_count + 1;
			core_last_wreg <= cpu_cmd.wreg;
			core_last_wdata <= cpu_cmd.wdata;
		end
	end

	// Response monitors sample mid cycle
	always @(negedge S_AXI_ACLK)
	if (S_AXI_ARESETN && dbg_rsp.bvalid && bready)
	begin
		check_word("bresp", {30'd0, dbg_rsp.bresp}, 32'd0);
		b_count++;
	end

	always @(negedge S_AXI_ACLK)
	if (S_AXI_ARESETN && dbg_rsp.rvalid && rready)
	begin
		assert (exp_q.size() != 0)
		else
		begin
			$display("Read data arrived while no read was outstanding");
			stop_on_error();
		end
		exp_rdata = exp_q.pop_front();
		check_word("rdata", dbg_rsp.rdata, exp_rdata);
		check_word("rresp", {30'd0, dbg_rsp.rresp}, 32'd0);
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge S_AXI_ACLK);
		$display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		stop_on_error();
	end

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////
	initial
	begin
		int n;
		int cnt;
		int bstart;
		logic [31:0] v;
		logic [31:0] data;
		logic is_wr;
		S_AXI_ARESETN = 1'b0;
		{awvalid, wvalid, arvalid} = 3'b000;
		{bready, rready} = 2'b11;
		awaddr = '0;
		wdata = '0;
		wstrb = '0;
		araddr = '0;
		{stall, brk, interrupt, cpu_reset_in} = 4'b0000;
		cc = 3'd0;
		lfsr = 16'd57;
		bp_en = 1'b0;
		b_count = 0;
		for (int i = 0; i < 32; i++)
			mirror[i] = fill_word(i);
		repeat (3) tick();
		S_AXI_ARESETN = 1'b1;

		// Reset hold after power-up
		n = 0;
		while (cpu_cmd.cpu_reset && n < RESET_DURATION + 4)
		begin
			tick();
			n++;
		end
		assert (n >= RESET_DURATION + 1 && n <= RESET_DURATION + 2)
		else
		begin
			$display("cpu_reset fell %0d cycles after reset, outside the allowed window", n);
			stop_on_error();
		end
		exp_reset = 1'b0;
		exp_halt = START_HALTED;
		check_bit("halt", cpu_cmd.halt, exp_halt);
		check_bit("bvalid", dbg_rsp.bvalid, 1'b0);
		check_bit("rvalid", dbg_rsp.rvalid, 1'b0);
		check_bit("we", cpu_cmd.we, 1'b0);
		check_bit("clear_cache", cpu_cmd.clear_cache, 1'b0);

		// Status reads over varied core inputs
		for (int k = 0; k < 4; k++)
		begin
			rand_bit(interrupt);
			rand_bit(stall);
			rand_bits(3, v);
			cc = v[2:0];
			read_word(CTRL_ADDR, exp_status(exp_reset, interrupt, exp_halt, stall, 1'b0, cc));
		end
		stall = 1'b0;

		// Single register write, halts the core
		cnt = core_wr_count;
		write_word(32'h14, 32'hDEAD_BEEF, 4'hF);
		wait_we_idle();
		mirror[5] = 32'hDEAD_BEEF;
		exp_halt = 1'b1;
		repeat (3) tick();
		check_word("core write count", core_wr_count, cnt + 1);
		check_word("wreg", {27'd0, core_last_wreg}, 32'd5);
		check_word("wdata", core_last_wdata, 32'hDEAD_BEEF);
		check_bit("halt", cpu_cmd.halt, exp_halt);
		read_word(32'h14, mirror[5]);

		// Release, halt, release
		write_word(CTRL_ADDR, 32'd0, 4'b0010);
		exp_halt = 1'b0;
		check_bit("halt", cpu_cmd.halt, exp_halt);
		write_word(CTRL_ADDR, 32'd1 << HALT_BIT, 4'b0010);
		exp_halt = 1'b1;
		check_bit("halt", cpu_cmd.halt, exp_halt);
		write_word(CTRL_ADDR, 32'd0, 4'b0010);
		exp_halt = 1'b0;
		check_bit("halt", cpu_cmd.halt, exp_halt);

		// Single step from halt, core busy for a while
		write_word(CTRL_ADDR, 32'd1 << HALT_BIT, 4'b0010);
		bstart = b_count;
		send_write(CTRL_ADDR, 32'd1 << STEP_BIT, 4'b0010);
		stall = 1'b1;
		check_bit("halt", cpu_cmd.halt, 1'b0);
		wait_bresp(bstart);
		repeat (2) tick();
		check_bit("halt", cpu_cmd.halt, 1'b0);
		stall = 1'b0;
		tick();
		exp_halt = 1'b1;
		check_bit("halt", cpu_cmd.halt, exp_halt);

		// Cache clear waits for a quiet core
		stall = 1'b1;
		bstart = b_count;
		send_write(CTRL_ADDR, (32'd1 << CLEAR_CACHE_BIT) | (32'd1 << HALT_BIT), 4'b0010);
		check_bit("clear_cache", cpu_cmd.clear_cache, 1'b1);
		check_bit("halt", cpu_cmd.halt, 1'b1);
		wait_bresp(bstart);
		tick();
		check_bit("clear_cache", cpu_cmd.clear_cache, 1'b1);
		stall = 1'b0;
		tick();
		check_bit("clear_cache", cpu_cmd.clear_cache, 1'b0);
		check_bit("halt", cpu_cmd.halt, exp_halt);

		// Reset bit in byte 0 gives a one cycle pulse
		bstart = b_count;
		send_write(CTRL_ADDR, 32'd1 << RESET_BIT, 4'b0001);
		check_bit("cpu_reset", cpu_cmd.cpu_reset, 1'b1);
		tick();
		exp_halt = START_HALTED;
		check_bit("cpu_reset", cpu_cmd.cpu_reset, 1'b0);
		check_bit("halt", cpu_cmd.halt, exp_halt);
		wait_bresp(bstart);
		read_word(CTRL_ADDR, exp_status(exp_reset, interrupt, exp_halt, stall, 1'b0, cc));

		// Break resets the core while held
		brk = 1'b1;
		tick();
		exp_reset = 1'b1;
		check_bit("cpu_reset", cpu_cmd.cpu_reset, exp_reset);
		read_word(CTRL_ADDR, exp_status(exp_reset, interrupt, exp_halt, stall, brk, cc));
		brk = 1'b0;
		tick();
		exp_reset = 1'b0;
		check_bit("cpu_reset", cpu_cmd.cpu_reset, exp_reset);
		read_word(CTRL_ADDR, exp_status(exp_reset, interrupt, exp_halt, stall, brk, cc));

		// Random register traffic under back-pressure
		bp_en = 1'b1;
		for (int k = 0; k < N_RAND; k++)
		begin
			rand_bit(is_wr);
			rand_bits(5, v);
			if (is_wr)
			begin
				rand_bits(32, data);
				cnt = core_wr_count;
				write_word({25'd0, v[4:0], 2'b00}, data, 4'hF);
				wait_we_idle();
				mirror[v[4:0]] = data;
				check_word("core write count", core_wr_count, cnt + 1);
				check_word("wdata", core_last_wdata, data);
			end
			else
				read_word({25'd0, v[4:0], 2'b00}, mirror[v[4:0]]);
		end
		// Full sweep against the mirror
		for (int i = 0; i < 32; i++)
			read_word(32'(i) << 2, mirror[i]);
		bp_en = 1'b0;
		tick();

		$display("=== PASS ===");
		$finish;
	end

endmodule

// ==== zip_dbg_ctrl.f ====
dbg_bus_pkg.sv
cpu_ctrl_pkg.sv
skid_buffer.sv
reset_hold_timer.sv
cpu_cmd_fsm.sv
dbg_write_path.sv
dbg_read_path.sv
zip_dbg_ctrl.sv
tb_zip_dbg_ctrl.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_zip_dbg_ctrl
FILELIST  = zip_dbg_ctrl.f
PASS_MSG  = === PASS ===

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf obj_dir
